//--- Bender.yml
package:
  name: adc16_ctrl

sources:
  # Design sources in compile order.
  - hw/adc16_ctrl_pkg.sv
  - hw/opb_reg_decoder.sv
  - hw/adc16_reg_bank.sv
  - hw/adc16_ctrl_top.sv

  # Testbench, which includes the vector table from test/.
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_adc16_ctrl.sv

//--- build.f
+incdir+test
hw/adc16_ctrl_pkg.sv
hw/opb_reg_decoder.sv
hw/adc16_reg_bank.sv
hw/adc16_ctrl_top.sv
test/tb_adc16_ctrl.sv

//--- hw/adc16_ctrl_pkg.sv
// Shared types and constants for the ADC16 OPB control block.
// All bus and register vectors use OPB numbering, where bit 0 is the MSB.
// Only words 0 to 2 of the window are mapped. Bursts are not supported.
package adc16_ctrl_pkg;

  // ****************************************
  // Address map.
  // ****************************************
  localparam logic [31:0] base_addr = 32'h0000_0000; // Window start.
  localparam logic [31:0] high_addr = 32'h0000_FFFF; // Window end, inclusive.

  // Word index from address bits 3:2.
  localparam logic [1:0] word_3wire  = 2'd0; // ADC 3-wire port.
  localparam logic [1:0] word_ctrl   = 2'd1; // Reset, snap, bitslip, tap.
  localparam logic [1:0] word_strobe = 2'd2; // Delay-reset strobes.

  localparam int num_lanes = 4; // Byte lanes per word.
  localparam int lane_w    = 8; // Bits per lane.

  // Revision bits replaced on read of word 0.
  localparam int rev_lo = 14;
  localparam int rev_hi = 15;

  // ****************************************
  // OPB bus.
  // ****************************************
  typedef struct packed {
    logic [0:31] abus;    // Byte address.
    logic [0:3]  be;      // Byte enables, be[0] covers bits 0 to 7.
    logic [0:31] dbus;    // Write data.
    logic        rnw;     // High for read.
    logic        select;  // Held until xfer_ack.
    logic        seqaddr; // Burst hint, ignored here.
  } opb_req_t;

  typedef struct packed {
    logic [0:31] dbus;     // Read data, zero outside acknowledge.
    logic        xfer_ack; // One-cycle acknowledge.
    logic        err_ack;  // Always low.
    logic        retry;    // Always low.
    logic        tout_sup; // Always low.
  } opb_rsp_t;

  // Decoded access from decoder to register bank.
  typedef struct packed {
    logic        wr;   // One-cycle write pulse.
    logic        rd;   // One-cycle read pulse.
    logic [1:0]  word; // Word index.
    logic [0:3]  be;
    logic [0:31] data;
  } reg_acc_t;

  // ****************************************
  // Register word views.
  // ****************************************
  // Word 0 layout.
  typedef struct packed {
    logic [0:13] rsvd_a;  // Bits 0 to 13.
    logic [0:1]  rev;     // Bits 14 and 15, revision on read.
    logic [0:5]  rsvd_b;  // Bits 16 to 21.
    logic        sclk;    // Bit 22.
    logic        sdata;   // Bit 23.
    logic [0:7]  csn_sel; // 24..27 ADC1 chip 4..1, 28..31 ADC0 chip 4..1.
  } reg_3wire_t;

  // Word 1 layout.
  typedef struct packed {
    logic [0:10] rsvd_a;    // Bits 0 to 10.
    logic        reset;     // Bit 11.
    logic [0:2]  rsvd_b;    // Bits 12 to 14.
    logic        snap_req;  // Bit 15.
    logic [0:7]  bitslip;   // Bits 16 to 23, chip H down to A.
    logic [0:2]  rsvd_c;    // Bits 24 to 26.
    logic [0:4]  delay_tap; // Bits 27 to 31.
  } reg_ctrl_t;

  // Raw view for lane writes, field views for decode.
  typedef union packed {
    logic [0:31] raw;
    reg_3wire_t  as_3wire;
    reg_ctrl_t   as_ctrl;
  } reg_word_u;

  // ****************************************
  // ADC-side outputs.
  // ****************************************
  typedef struct packed {
    logic [1:4] csn;   // Active low, csn[1] is chip 1.
    logic       sdata;
    logic       sclk;
  } adc3wire_t;

  typedef struct packed {
    logic        reset;
    logic        snap_req;
    logic [0:7]  iserdes_bitslip; // Chip H first.
    logic [0:4]  delay_tap;
    logic [0:31] delay_rst;       // One-cycle strobes, one per lane pair.
  } adc16_ctl_t;

endpackage

//--- hw/adc16_ctrl_top.sv
// Top level of the ADC16 OPB control block.
// Drives two quad-ADC boards from one shared 3-wire port.
// The master must supply its own bus timeout for unmapped words.
`timescale 1ns/1ps

module adc16_ctrl_top
  import adc16_ctrl_pkg::*;
(
  // ****************************************
  // Bus side.
  // ****************************************
  input  logic       OPB_Clk,
  input  logic       rst_n,      // Synchronous, active low.
  input  opb_req_t   opb_req,    // From bus master.
  output opb_rsp_t   opb_rsp,    // To bus master.

  // ****************************************
  // Board side.
  // ****************************************
  input  logic [1:0] roach2_rev, // Static board revision.
  output adc3wire_t  adc0_3wire, // Board 0 config port.
  output adc3wire_t  adc1_3wire, // Board 1 config port.
  output adc16_ctl_t ctl         // Reset, snap, bitslip, delay.
);

  // ****************************************
  // Internal nets.
  // ****************************************
  reg_acc_t    acc;     // Decoded access.
  logic [0:31] rd_data; // Registered read word.

  // ****************************************
  // Bus decoder.
  // ****************************************
  // Address match and acknowledge.
  opb_reg_decoder i_decoder (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .opb_req (opb_req),
    .rd_data (rd_data),
    .acc     (acc),
    .opb_rsp (opb_rsp)
  );

  // ****************************************
  // Register bank.
  // ****************************************
  // Storage, strobes and pin mapping.
  adc16_reg_bank i_reg_bank (
    .OPB_Clk    (OPB_Clk),
    .rst_n      (rst_n),
    .acc        (acc),
    .roach2_rev (roach2_rev),
    .rd_data    (rd_data),
    .adc0_3wire (adc0_3wire),
    .adc1_3wire (adc1_3wire),
    .ctl        (ctl)
  );

endmodule

//--- hw/adc16_reg_bank.sv
// Control registers for the 16-channel ADC front end.
// Words 0 and 1 are byte-lane writable; word 2 holds one-cycle strobes only.
// Read data is registered and valid one cycle after acc.rd.
`timescale 1ns/1ps

module adc16_reg_bank
  import adc16_ctrl_pkg::*;
(
  input  logic        OPB_Clk,
  input  logic        rst_n,      // Synchronous, active low.
  input  reg_acc_t    acc,
  input  logic [1:0]  roach2_rev, // Static board revision.
  output logic [0:31] rd_data,
  output adc3wire_t   adc0_3wire,
  output adc3wire_t   adc1_3wire,
  output adc16_ctl_t  ctl
);

  // ****************************************
  // Storage.
  // ****************************************
  reg_word_u   w3_q;     // Word 0, 3-wire port.
  reg_word_u   ctrl_q;   // Word 1, control.
  logic [0:31] strobe_q; // Word 2, self-clearing.
  reg_word_u   rd_word;  // Read mux output.
  logic [0:31] rd_q;     // Registered read data.

  // Merge enabled byte lanes of new_word over old_word.
  function automatic logic [0:31] lane_merge(input logic [0:31]          old_word,
                                             input logic [0:31]          new_word,
                                             input logic [0:num_lanes-1] lane_en);
    logic [0:31] merged;
    merged = old_word;
    for (int l = 0; l < num_lanes; l++) begin
      if (lane_en[l]) begin
        merged[l*lane_w +: lane_w] = new_word[l*lane_w +: lane_w]; // Lane 0 is bits 0..7.
      end
    end
    return merged;
  endfunction

  // ****************************************
  // Words 0 and 1.
  // ****************************************
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      w3_q.raw   <= '0;
      ctrl_q.raw <= '0;
    end else if (acc.wr) begin
      if (acc.word == word_3wire) begin
        w3_q.raw <= lane_merge(w3_q.raw, acc.data, acc.be);
      end
      if (acc.word == word_ctrl) begin
        ctrl_q.raw <= lane_merge(ctrl_q.raw, acc.data, acc.be);
      end
    end
  end

  // ****************************************
  // Word 2 strobes.
  // ****************************************
  // Loaded on the write edge, cleared on the next.
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      strobe_q <= '0;
    end else if (acc.wr && (acc.word == word_strobe)) begin
      strobe_q <= lane_merge('0, acc.data, acc.be); // Disabled lanes stay low.
    end else begin
      strobe_q <= '0;
    end
  end

  // ****************************************
  // Read back.
  // ****************************************
  always_comb begin
    rd_word.raw = '0;
    case (acc.word)
      word_3wire: begin
        rd_word                    = w3_q;
        rd_word.raw[rev_lo:rev_hi] = roach2_rev; // Revision replaces stored bits.
      end
      word_ctrl: begin
        rd_word = ctrl_q;
      end
      word_strobe: begin
        rd_word.raw = '0; // Strobes are gone by read time.
      end
      default: begin
        rd_word.raw = '0; // Never requested.
      end
    endcase
  end

  // Read word for the acknowledge cycle.
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      rd_q <= '0;
    end else if (acc.rd) begin
      rd_q <= rd_word.raw;
    end
  end

  assign rd_data = rd_q;

  // ****************************************
  // ADC pin mapping.
  // ****************************************
  // Shared clock and data on both boards.
  always_comb begin
    adc0_3wire.sclk  = w3_q.as_3wire.sclk;
    adc1_3wire.sclk  = w3_q.as_3wire.sclk;
    adc0_3wire.sdata = w3_q.as_3wire.sdata;
    adc1_3wire.sdata = w3_q.as_3wire.sdata;
    // Selects stored active high, driven active low.
    for (int c = 1; c <= 4; c++) begin
      adc1_3wire.csn[c] = ~w3_q.as_3wire.csn_sel[4 - c]; // Bits 24..27.
      adc0_3wire.csn[c] = ~w3_q.as_3wire.csn_sel[8 - c]; // Bits 28..31.
    end
  end

  // Control outputs.
  always_comb begin
    ctl.reset           = ctrl_q.as_ctrl.reset;
    ctl.snap_req        = ctrl_q.as_ctrl.snap_req;
    ctl.iserdes_bitslip = ctrl_q.as_ctrl.bitslip;
    ctl.delay_tap       = ctrl_q.as_ctrl.delay_tap;
    ctl.delay_rst       = strobe_q; // Pairs H4 H1 down to A4 A1.
  end

endmodule

//--- hw/opb_reg_decoder.sv
// OPB slave front end for the ADC16 register window.
// One-cycle acknowledge, never two in a row; unmapped words are not acknowledged.
// Error, retry and timeout-suppress are tied low; seqaddr is ignored.
`timescale 1ns/1ps

module opb_reg_decoder
  import adc16_ctrl_pkg::*;
(
  input  logic        OPB_Clk,
  input  logic        rst_n,    // Synchronous, active low.
  input  opb_req_t    opb_req,
  input  logic [0:31] rd_data,  // Valid in the acknowledge cycle.
  output reg_acc_t    acc,
  output opb_rsp_t    opb_rsp
);

  // ****************************************
  // Address decode.
  // ****************************************
  logic        in_window;   // Address inside base..high.
  logic [31:0] offset;      // Byte offset from base.
  logic [1:0]  word;        // Word index.
  logic        word_mapped; // Word 0, 1 or 2.
  logic        hit;         // Accepted access this cycle.
  logic        ack_q;       // Acknowledge register.

  assign in_window = (opb_req.abus >= base_addr) && (opb_req.abus <= high_addr);
  assign offset    = opb_req.abus - base_addr;
  assign word      = offset[3:2]; // Byte address bits, not OPB numbering.

  // Word 3 falls through, the master times out.
  assign word_mapped = (word == word_3wire) ||
                       (word == word_ctrl)  ||
                       (word == word_strobe);

  // No new access while acknowledging.
  assign hit = opb_req.select && in_window && word_mapped && !ack_q;

  // ****************************************
  // Request to register bank.
  // ****************************************
  // Combinational, so the bank updates on the acknowledge edge.
  always_comb begin
    acc.wr   = hit && !opb_req.rnw; // Write pulse.
    acc.rd   = hit &&  opb_req.rnw; // Read pulse.
    acc.word = word;
    acc.be   = opb_req.be;
    acc.data = opb_req.dbus;
  end

  // ****************************************
  // Acknowledge.
  // ****************************************
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit; // High for exactly one cycle per hit.
    end
  end

  // ****************************************
  // Response to master.
  // ****************************************
  always_comb begin
    opb_rsp.dbus     = ack_q ? rd_data : '0; // Bus stays zero when idle.
    opb_rsp.xfer_ack = ack_q;
    opb_rsp.err_ack  = 1'b0;
    opb_rsp.retry    = 1'b0;
    opb_rsp.tout_sup = 1'b0;
  end

endmodule

//--- test/tb_adc16_vectors.svh
// Stimulus table for the ADC16 control testbench, applied top to bottom.
// Columns: name, op, byte address, be (OPB order), data, exp.
// exp is the read data (revision bits are filled in by the testbench),
// or the delay_rst pattern for word 2 writes, and zero otherwise.
`ifndef TB_ADC16_VECTORS_SVH
`define TB_ADC16_VECTORS_SVH

typedef enum logic [1:0] {
  op_write,      // Acknowledged write.
  op_read,       // Acknowledged read, compared with exp.
  op_write_nack, // Write that must time out.
  op_read_nack   // Read that must time out.
} vec_op_e;

task automatic load_vectors();
  // Word 0, shared sclk/sdata and chip selects.
  add_vector("w0_adc1_sel",  op_write, 32'h0000_0000, 4'b1111, 32'h0003_03C5, 32'h0);
  add_vector("r0_adc1_sel",  op_read,  32'h0000_0000, 4'b1111, 32'h0,         32'h0003_03C5);
  add_vector("w0_adc0_sel",  op_write, 32'h0000_0000, 4'b1111, 32'h0000_010A, 32'h0);
  add_vector("r0_adc0_sel",  op_read,  32'h0000_0000, 4'b1111, 32'h0,         32'h0000_010A);

  // Word 1, one lane at a time, then mixed.
  add_vector("w1_full",      op_write, 32'h0000_0004, 4'b1111, 32'h0011_5A1F, 32'h0);
  add_vector("r1_full",      op_read,  32'h0000_0004, 4'b1111, 32'h0,         32'h0011_5A1F);
  add_vector("w1_lane0",     op_write, 32'h0000_0004, 4'b1000, 32'hFFFF_FFFF, 32'h0);
  add_vector("r1_lane0",     op_read,  32'h0000_0004, 4'b1111, 32'h0,         32'hFF11_5A1F);
  add_vector("w1_lane1",     op_write, 32'h0000_0004, 4'b0100, 32'h0000_0000, 32'h0);
  add_vector("r1_lane1",     op_read,  32'h0000_0004, 4'b1111, 32'h0,         32'hFF00_5A1F);
  add_vector("w1_lane2",     op_write, 32'h0000_0004, 4'b0010, 32'h1234_C356, 32'h0);
  add_vector("r1_lane2",     op_read,  32'h0000_0004, 4'b1111, 32'h0,         32'hFF00_C31F);
  add_vector("w1_lane3",     op_write, 32'h0000_0004, 4'b0001, 32'hAAAA_AA05, 32'h0);
  add_vector("r1_lane3",     op_read,  32'h0000_0004, 4'b1111, 32'h0,         32'hFF00_C305);
  add_vector("w1_mix_1010",  op_write, 32'h0000_0004, 4'b1010, 32'h0110_2233, 32'h0);
  add_vector("w1_mix_0101",  op_write, 32'h0000_0004, 4'b0101, 32'h9911_8807, 32'h0);
  add_vector("r1_mixed",     op_read,  32'h0000_0004, 4'b1111, 32'h0,         32'h0111_2207);
  add_vector("w1_no_lanes",  op_write, 32'h0000_0004, 4'b0000, 32'hFFFF_FFFF, 32'h0);
  add_vector("r1_no_lanes",  op_read,  32'h0000_0004, 4'b1111, 32'h0,         32'h0111_2207);

  // Word 2, self-clearing strobes.
  add_vector("w2_full",      op_write, 32'h0000_0008, 4'b1111, 32'h8001_0F0F, 32'h8001_0F0F);
  add_vector("w2_masked",    op_write, 32'h0000_0008, 4'b0110, 32'hFFFF_FFFF, 32'h00FF_FF00);
  add_vector("r2_zero",      op_read,  32'h0000_0008, 4'b1111, 32'h0,         32'h0);

  // Unmapped word 3 and out of window.
  add_vector("w3_no_ack",    op_write_nack, 32'h0000_000C, 4'b1111, 32'hFFFF_FFFF, 32'h0);
  add_vector("r3_no_ack",    op_read_nack,  32'h0000_000C, 4'b1111, 32'h0,         32'h0);
  add_vector("w_high_no_ack", op_write_nack, 32'h0001_0000, 4'b1111, 32'hFFFF_FFFF, 32'h0);
  add_vector("r_high_no_ack", op_read_nack,  32'h0001_0004, 4'b1111, 32'h0,         32'h0);
  add_vector("r0_unchanged", op_read,  32'h0000_0000, 4'b1111, 32'h0,         32'h0000_010A);
  add_vector("r1_unchanged", op_read,  32'h0000_0004, 4'b1111, 32'h0,         32'h0111_2207);
endtask

`endif

//--- test/tb_adc16_ctrl.sv
// Testbench for the ADC16 OPB control block.
// Inputs change on the falling edge, outputs are sampled on the falling edge.
// Each bus access waits at most ack_timeout cycles for xfer_ack.
`timescale 1ns/1ps

module tb_adc16_ctrl
  import adc16_ctrl_pkg::*;
();

  localparam int ack_timeout = 20; // Cycles per bus access.

  logic       OPB_Clk;
  logic       rst_n;
  opb_req_t   opb_req;
  opb_rsp_t   opb_rsp;
  logic [1:0] roach2_rev;
  adc3wire_t  adc0_3wire;
  adc3wire_t  adc1_3wire;
  adc16_ctl_t ctl;

  int          error_count = 0;
  int          check_count = 0;
  logic [0:31] model [0:1]; // Expected words 0 and 1.

  `include "tb_adc16_vectors.svh"

  // Vector table, filled by load_vectors.
  string       vec_name [$];
  vec_op_e     vec_op   [$];
  logic [31:0] vec_addr [$];
  logic [0:3]  vec_be   [$];
  logic [0:31] vec_data [$];
  logic [0:31] vec_exp  [$];

  adc16_ctrl_top i_dut (
    .OPB_Clk    (OPB_Clk),
    .rst_n      (rst_n),
    .opb_req    (opb_req),
    .opb_rsp    (opb_rsp),
    .roach2_rev (roach2_rev),
    .adc0_3wire (adc0_3wire),
    .adc1_3wire (adc1_3wire),
    .ctl        (ctl)
  );

  always #20 OPB_Clk = ~OPB_Clk; // 40 ns period.

  // ****************************************
  // Table and model helpers.
  // ****************************************
  task automatic add_vector(input string name, input vec_op_e op, input logic [31:0] addr,
                            input logic [0:3] be, input logic [0:31] data,
                            input logic [0:31] exp);
    vec_name.push_back(name);
    vec_op.push_back(op);
    vec_addr.push_back(addr);
    vec_be.push_back(be);
    vec_data.push_back(data);
    vec_exp.push_back(exp);
  endtask

  // Byte lane rule, be[0] covers bits 0 to 7.
  function automatic logic [0:31] apply_byte_enables(input logic [0:31] old_word,
                                                     input logic [0:31] new_word,
                                                     input logic [0:3]  be);
    logic [0:31] w;
    w = old_word;
    for (int l = 0; l < 4; l++) begin
      if (be[l]) w[l*8 +: 8] = new_word[l*8 +: 8];
    end
    return w;
  endfunction

  // Board 1 uses bits 24..27, board 0 bits 28..31, chip 4 first.
  function automatic adc3wire_t expect_3wire(input logic [0:31] w, input bit board0);
    adc3wire_t e;
    int        last;
    last    = board0 ? 32 : 28;
    e.sclk  = w[22];
    e.sdata = w[23];
    for (int c = 1; c <= 4; c++) begin
      e.csn[c] = ~w[last - c]; // Active low.
    end
    return e;
  endfunction

  function automatic adc16_ctl_t expect_ctl(input logic [0:31] w, input logic [0:31] strobe);
    adc16_ctl_t e;
    e.reset           = w[11];
    e.snap_req        = w[15];
    e.iserdes_bitslip = w[16:23];
    e.delay_tap       = w[27:31];
    e.delay_rst       = strobe;
    return e;
  endfunction

  // ****************************************
  // Compare tasks.
  // ****************************************
  task automatic check_word(input string name, input logic [0:31] exp, input logic [0:31] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_3wire(input string name, input adc3wire_t exp, input adc3wire_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_ctl(input string name, input adc16_ctl_t exp, input adc16_ctl_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // All pins against the model.
  task automatic check_outputs(input string name, input logic [0:31] strobe);
    check_3wire({name, " adc0"}, expect_3wire(model[0], 1'b1), adc0_3wire);
    check_3wire({name, " adc1"}, expect_3wire(model[0], 1'b0), adc1_3wire);
    check_ctl({name, " ctl"}, expect_ctl(model[1], strobe), ctl);
  endtask

  // ****************************************
  // Bus access.
  // ****************************************
  // Call on a falling edge, returns on the acknowledge sample.
  task automatic bus_access(input string name, input logic rnw, input logic [31:0] addr,
                            input logic [0:3] be, input logic [0:31] data,
                            input bit expect_ack, output logic [0:31] rdata);
    int cyc;
    bit acked;
    cyc            = 0;
    acked          = 1'b0;
    rdata          = '0;
    opb_req.abus   = addr;
    opb_req.be     = be;
    opb_req.dbus   = rnw ? '0 : data;
    opb_req.rnw    = rnw;
    opb_req.select = 1'b1;
    while (!acked && cyc < ack_timeout) begin
      @(negedge OPB_Clk);
      cyc++;
      // Error, retry and timeout-suppress stay low.
      check_word({name, " status"}, '0,
                 {29'b0, opb_rsp.err_ack, opb_rsp.retry, opb_rsp.tout_sup});
      if (opb_rsp.xfer_ack) begin
        acked = 1'b1;
        rdata = opb_rsp.dbus;
      end else begin
        check_word({name, " idle dbus"}, '0, opb_rsp.dbus); // No data without ack.
      end
    end
    opb_req = '0; // Release the bus.
    if (expect_ack && !acked) begin
      error_count++;
      $display("Timeout: %s got no xfer_ack within %0d cycles", name, ack_timeout);
    end else if (!expect_ack && acked) begin
      error_count++;
      $display("Unexpected xfer_ack: %s at address %h", name, addr);
    end
  endtask

  // ****************************************
  // Main sequence.
  // ****************************************
  initial begin
    logic [0:31] rdata;
    logic [0:31] exp_rd;
    logic [31:0] addr;
    logic [0:3]  be;
    logic [0:31] data;
    int          word;
    OPB_Clk    = 1'b0;
    rst_n      = 1'b0;
    opb_req    = '0;
    roach2_rev = 2'b00;
    model[0]   = '0;
    model[1]   = '0;
    void'($urandom(32'h2e2c)); // Single seed for the run.
    roach2_rev = $urandom;
    load_vectors();
    repeat (8) @(negedge OPB_Clk);
    rst_n = 1'b1;

    // Reset state.
    check_outputs("reset", '0);
    check_word("reset xfer_ack", '0, {31'b0, opb_rsp.xfer_ack});
    check_word("reset dbus", '0, opb_rsp.dbus);
    check_word("reset status", '0,
               {29'b0, opb_rsp.err_ack, opb_rsp.retry, opb_rsp.tout_sup});

    foreach (vec_name[i]) begin
      word = vec_addr[i][3:2];
      case (vec_op[i])
        op_write: begin
          bus_access(vec_name[i], 1'b0, vec_addr[i], vec_be[i], vec_data[i], 1'b1, rdata);
          if (word == word_strobe) begin
            check_outputs(vec_name[i], vec_exp[i]); // Strobe during ack only.
            @(negedge OPB_Clk);
            check_outputs({vec_name[i], " cleared"}, '0);
          end else begin
            model[word] = apply_byte_enables(model[word], vec_data[i], vec_be[i]);
            check_outputs(vec_name[i], '0);
          end
        end
        op_read: begin
          bus_access(vec_name[i], 1'b1, vec_addr[i], vec_be[i], '0, 1'b1, rdata);
          exp_rd = vec_exp[i];
          if (word == word_3wire) exp_rd[rev_lo:rev_hi] = roach2_rev;
          check_word(vec_name[i], exp_rd, rdata);
        end
        default: begin
          bus_access(vec_name[i], vec_op[i] == op_read_nack, vec_addr[i], vec_be[i],
                     vec_data[i], 1'b0, rdata);
          check_outputs(vec_name[i], '0); // Nothing may move.
        end
      endcase
    end

    // Random lane writes to words 0 and 1, checked against the model.
    for (int n = 0; n < 8; n++) begin
      word = $urandom % 2;
      addr = word << 2;
      be   = $urandom;
      data = $urandom;
      bus_access($sformatf("rand %0d write", n), 1'b0, addr, be, data, 1'b1, rdata);
      model[word] = apply_byte_enables(model[word], data, be);
      check_outputs($sformatf("rand %0d write", n), '0);
      bus_access($sformatf("rand %0d read", n), 1'b1, addr, 4'b1111, '0, 1'b1, rdata);
      exp_rd = model[word];
      if (word == word_3wire) exp_rd[rev_lo:rev_hi] = roach2_rev;
      check_word($sformatf("rand %0d read", n), exp_rd, rdata);
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
